//--- include/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Register index widths
`define LRF_IDX_W 5  // Architectural register index
`define PRF_IDX_W 6  // Physical register index

// Table sizes
`define MT_NUM  32  // One map entry per architectural register
`define PRF_NUM 64  // Physical register file depth
`define FL_NUM  32  // Free list capacity

// Free list pointer carries one extra wrap bit above the index
`define FL_PTR_W 6

// Branch checkpoint depth
`define CKPT_NUM 4

// Hardwired zero register, mapped to the physical register of the same number
`define ZERO_REG 31

`endif

//--- rtl/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

  // Architectural register index
  typedef logic [`LRF_IDX_W-1:0] areg_t;

  // Physical register name
  typedef logic [`PRF_IDX_W-1:0] preg_t;

  // Map entry: ready bit in the MSB, physical name below it
  typedef logic [`PRF_IDX_W:0] mt_entry_t;

  // Whole map table packed, entry i at slice i
  typedef mt_entry_t [`MT_NUM-1:0] mt_snap_t;

  // Free list pointer with wrap bit
  typedef logic [`FL_PTR_W-1:0] fl_ptr_t;

  // Map table update mode
  typedef enum logic {
    MT_NORMAL   = 1'b0,  // CDB update plus rename
    MT_ROLLBACK = 1'b1   // Reload from the oldest checkpoint
  } mt_mode_t;

endpackage

//--- rtl/ckpt_if.sv
`timescale 1ns/1ps

// Snapshot and recovery path between the map table, free list and checkpoint queue
interface ckpt_if import rename_pkg::*; ();

  mt_snap_t snap;        // Next-cycle map contents
  fl_ptr_t  fl_head;     // Free list head after this cycle's pop
  logic     take;        // Branch dispatching, store a checkpoint
  logic     restore;     // Mispredict resolving this cycle
  mt_snap_t rc_snap;     // Map contents to restore
  fl_ptr_t  rc_fl_head;  // Free list head to restore

  modport mt (
    output snap, take,
    input  restore, rc_snap
  );

  modport fl (
    output fl_head,
    input  restore, rc_fl_head
  );

  modport cq (
    input  snap, fl_head, take,
    output restore, rc_snap, rc_fl_head
  );

endinterface

//--- rtl/map_table.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module map_table import rename_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // Dispatch side
  input  logic  dispatch_valid_i,
  output logic  dispatch_ready_o,
  input  logic  is_branch_i,
  input  logic  dest_wr_i,
  input  areg_t opa_areg_i,
  input  areg_t opb_areg_i,
  input  areg_t dest_areg_i,
  // Free list
  input  preg_t free_preg_i,
  input  logic  fl_empty_i,
  output logic  alloc_o,
  // Checkpoint queue status
  input  logic  ckpt_full_i,
  // CDB broadcast
  input  logic  cdb_valid_i,
  input  preg_t cdb_preg_i,
  input  logic  br_mispredict_i,
  // Rename results
  output preg_t opa_preg_o,
  output logic  opa_rdy_o,
  output preg_t opb_preg_o,
  output logic  opb_rdy_o,
  output preg_t dest_preg_o,
  output preg_t dest_old_preg_o,
  ckpt_if.mt    ckpt
);

  localparam mt_entry_t ZERO_ENTRY = {1'b1, preg_t'(`ZERO_REG)};  // Pinned and always ready

  mt_snap_t mt_q;       // Live map
  mt_snap_t mt_d;       // Map at the next edge
  mt_mode_t mode;
  logic     writes_reg; // Instruction really needs a new register
  logic     fire;       // Handshake completes this cycle

  // Reads come straight from the stored map, no CDB bypass
  assign opa_preg_o      = mt_q[opa_areg_i][`PRF_IDX_W-1:0];
  assign opa_rdy_o       = mt_q[opa_areg_i][`PRF_IDX_W];
  assign opb_preg_o      = mt_q[opb_areg_i][`PRF_IDX_W-1:0];
  assign opb_rdy_o       = mt_q[opb_areg_i][`PRF_IDX_W];
  assign dest_old_preg_o = mt_q[dest_areg_i][`PRF_IDX_W-1:0];  // Freed later at retire

  // Branches and zero register writes are not renamed
  assign writes_reg = dest_wr_i && !is_branch_i && (dest_areg_i != areg_t'(`ZERO_REG));

  // Stall on empty free list, full queue or a mispredict in flight
  assign dispatch_ready_o = !(writes_reg && fl_empty_i) &&
                            !(is_branch_i && ckpt_full_i) &&
                            !br_mispredict_i;

  assign fire    = dispatch_valid_i && dispatch_ready_o;
  assign alloc_o = fire && writes_reg;   // Pop the free list head
  assign ckpt.take = fire && is_branch_i; // Snapshot on branch dispatch

  // New name when renaming, else the unchanged mapping
  assign dest_preg_o = writes_reg ? free_preg_i : dest_old_preg_o;

  assign mode = ckpt.restore ? MT_ROLLBACK : MT_NORMAL;

  always_comb begin
    case (mode)
      MT_ROLLBACK: mt_d = ckpt.rc_snap;  // Whole table from the oldest checkpoint
      default:     mt_d = mt_q;
    endcase

    // Broadcast marks every matching entry ready
    if (cdb_valid_i) begin
      for (int i = 0; i < `MT_NUM; i++) begin
        if (mt_d[i][`PRF_IDX_W-1:0] == cdb_preg_i) begin
          mt_d[i][`PRF_IDX_W] = 1'b1;
        end
      end
    end

    // Rename after CDB so the new name starts not ready
    if (mode == MT_NORMAL && alloc_o) begin
      mt_d[dest_areg_i] = {1'b0, free_preg_i};
    end

    mt_d[`ZERO_REG] = ZERO_ENTRY;
  end

  // Checkpoint gets the table as it will look after this edge
  assign ckpt.snap = mt_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MT_NUM; i++) begin
        mt_q[i] <= {1'b1, preg_t'(i)};  // Identity map, all ready
      end
    end else begin
      mt_q <= mt_d;
    end
  end

endmodule

//--- rtl/free_list.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list import rename_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  alloc_i,         // Pop one register at the head
  input  logic  retire_valid_i,  // Push a freed register at the tail
  input  preg_t retire_preg_i,
  output preg_t free_preg_o,     // Register handed out next
  output logic  empty_o,
  ckpt_if.fl    ckpt
);

  localparam int FL_IDX_W = `FL_PTR_W - 1;  // Index bits below the wrap bit

  preg_t   fl_mem [`FL_NUM];  // Circular buffer of free names
  fl_ptr_t head_q;
  fl_ptr_t tail_q;
  fl_ptr_t head_nxt;          // Head after this cycle's pop
  logic    full;

  logic [FL_IDX_W-1:0] head_idx;
  logic [FL_IDX_W-1:0] tail_idx;

  assign head_idx = head_q[FL_IDX_W-1:0];
  assign tail_idx = tail_q[FL_IDX_W-1:0];

  // Same index with equal wrap bits means empty, different wrap bits means full
  assign empty_o = (head_q == tail_q);
  assign full    = (head_idx == tail_idx) && (head_q[FL_IDX_W] != tail_q[FL_IDX_W]);

  // A retire lands at the tail, so it never shows at the head in the same cycle
  assign free_preg_o = fl_mem[head_idx];

  assign head_nxt     = alloc_i ? head_q + fl_ptr_t'(1) : head_q;
  assign ckpt.fl_head = head_nxt;  // Saved with each branch checkpoint

  // Pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      tail_q <= fl_ptr_t'(`FL_NUM);  // Starts full
    end else begin
      // Rewinding the head frees everything popped after the branch
      if (ckpt.restore) begin
        head_q <= ckpt.rc_fl_head;
      end else begin
        head_q <= head_nxt;
      end
      // Tail is never rewound so retired names stay free
      if (retire_valid_i && !full) begin
        tail_q <= tail_q + fl_ptr_t'(1);
      end
    end
  end

  // Storage loaded with the upper half of the register file
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FL_NUM; i++) begin
        fl_mem[i] <= preg_t'(`PRF_NUM - `FL_NUM + i);
      end
    end else if (retire_valid_i && !full) begin
      fl_mem[tail_idx] <= retire_preg_i;
    end
  end

endmodule

//--- rtl/checkpoint_queue.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module checkpoint_queue import rename_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cdb_valid_i,
  input  preg_t cdb_preg_i,
  input  logic  br_resolve_i,     // Oldest branch resolves
  input  logic  br_mispredict_i,  // Qualifies the resolve as wrong
  output logic  full_o,
  ckpt_if.cq    ckpt
);

  localparam int CQ_IDX_W = $clog2(`CKPT_NUM);

  typedef logic [CQ_IDX_W-1:0] cq_ptr_t;
  typedef logic [CQ_IDX_W:0]   cq_cnt_t;

  mt_snap_t snap_mem [`CKPT_NUM];  // Stored map copies
  fl_ptr_t  head_mem [`CKPT_NUM];  // Free list head at each branch
  cq_ptr_t  rd_ptr;                // Oldest checkpoint
  cq_ptr_t  wr_ptr;                // Next free slot
  cq_cnt_t  count;
  logic     empty;
  logic     push;
  logic     pop;
  logic     flush;

  function automatic cq_ptr_t ptr_inc(input cq_ptr_t ptr);
    cq_ptr_t res;
    if (ptr == cq_ptr_t'(`CKPT_NUM - 1)) begin
      res = '0;
    end else begin
      res = ptr + cq_ptr_t'(1);
    end
    return res;
  endfunction

  assign empty  = (count == '0);
  assign full_o = (count == cq_cnt_t'(`CKPT_NUM));

  assign push  = ckpt.take;  // Map table already stalls a branch when full
  assign pop   = br_resolve_i && !br_mispredict_i && !empty;  // Correct prediction
  assign flush = br_resolve_i && br_mispredict_i && !empty;   // Wrong prediction

  // Oldest entry belongs to the resolving branch
  assign ckpt.restore    = flush;
  assign ckpt.rc_snap    = snap_mem[rd_ptr];
  assign ckpt.rc_fl_head = head_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // All younger checkpoints are discarded too
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + cq_cnt_t'(1);
        2'b01:   count <= count - cq_cnt_t'(1);
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Stored copies track CDB just like the live table
  always_ff @(posedge clk) begin
    for (int s = 0; s < `CKPT_NUM; s++) begin
      if (push && wr_ptr == cq_ptr_t'(s)) begin
        snap_mem[s] <= ckpt.snap;  // Already holds this cycle's broadcast
        head_mem[s] <= ckpt.fl_head;
      end else if (cdb_valid_i) begin
        for (int e = 0; e < `MT_NUM; e++) begin
          if (snap_mem[s][e][`PRF_IDX_W-1:0] == cdb_preg_i) begin
            snap_mem[s][e][`PRF_IDX_W] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- rtl/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // Dispatch
  input  logic  dispatch_valid_i,
  output logic  dispatch_ready_o,
  input  logic  is_branch_i,
  input  logic  dest_wr_i,
  input  areg_t opa_areg_i,
  input  areg_t opb_areg_i,
  input  areg_t dest_areg_i,
  // Rename results
  output preg_t opa_preg_o,
  output logic  opa_rdy_o,
  output preg_t opb_preg_o,
  output logic  opb_rdy_o,
  output preg_t dest_preg_o,
  output preg_t dest_old_preg_o,
  // CDB
  input  logic  cdb_valid_i,
  input  preg_t cdb_preg_i,
  // Branch resolution from the ROB side
  input  logic  br_resolve_i,
  input  logic  br_mispredict_i,
  // Retirement frees old names
  input  logic  retire_valid_i,
  input  preg_t retire_preg_i
);

  logic  alloc;      // Map table pops the free list
  preg_t free_preg;  // Head of the free list
  logic  fl_empty;
  logic  ckpt_full;

  ckpt_if ckpt ();  // Snapshot and recovery bundle

  map_table u_map_table (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_ready_o (dispatch_ready_o),
    .is_branch_i      (is_branch_i),
    .dest_wr_i        (dest_wr_i),
    .opa_areg_i       (opa_areg_i),
    .opb_areg_i       (opb_areg_i),
    .dest_areg_i      (dest_areg_i),
    .free_preg_i      (free_preg),
    .fl_empty_i       (fl_empty),
    .alloc_o          (alloc),
    .ckpt_full_i      (ckpt_full),
    .cdb_valid_i      (cdb_valid_i),
    .cdb_preg_i       (cdb_preg_i),
    .br_mispredict_i  (br_mispredict_i),
    .opa_preg_o       (opa_preg_o),
    .opa_rdy_o        (opa_rdy_o),
    .opb_preg_o       (opb_preg_o),
    .opb_rdy_o        (opb_rdy_o),
    .dest_preg_o      (dest_preg_o),
    .dest_old_preg_o  (dest_old_preg_o),
    .ckpt             (ckpt.mt)
  );

  free_list u_free_list (
    .clk            (clk),
    .rst            (rst),
    .alloc_i        (alloc),
    .retire_valid_i (retire_valid_i),
    .retire_preg_i  (retire_preg_i),
    .free_preg_o    (free_preg),
    .empty_o        (fl_empty),
    .ckpt           (ckpt.fl)
  );

  checkpoint_queue u_checkpoint_queue (
    .clk             (clk),
    .rst             (rst),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_preg_i      (cdb_preg_i),
    .br_resolve_i    (br_resolve_i),
    .br_mispredict_i (br_mispredict_i),
    .full_o          (ckpt_full),
    .ckpt            (ckpt.cq)
  );

endmodule

//--- tb/tb_rename_stage.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module tb_rename_stage import rename_pkg::*; ();

  // Roughly twice the cycles that reset and the six tests take
  localparam int MAX_CYCLES = 2 * (5 + 32 + 18 + 4 + 7 + 11 + 33);

  logic  clk;
  logic  rst;
  logic  dispatch_valid_i, is_branch_i, dest_wr_i;
  areg_t opa_areg_i, opb_areg_i, dest_areg_i;
  logic  cdb_valid_i, br_resolve_i, br_mispredict_i, retire_valid_i;
  preg_t cdb_preg_i, retire_preg_i;
  logic  dispatch_ready_o, opa_rdy_o, opb_rdy_o;
  preg_t opa_preg_o, opb_preg_o, dest_preg_o, dest_old_preg_o;

  // Reference model of the map, ready bits, free list and checkpoints
  preg_t       m_map [`MT_NUM];
  logic        m_rdy [`MT_NUM];
  preg_t       fl_mem [`FL_NUM];
  int          fl_head, fl_tail;  // Running counts, slot is count modulo FL_NUM
  preg_t       ck_map [`CKPT_NUM][`MT_NUM];
  logic        ck_rdy [`CKPT_NUM][`MT_NUM];
  int          ck_head [`CKPT_NUM];
  int          ck_cnt;            // Oldest checkpoint sits in slot 0
  logic [31:0] seed = 32'h8006_46bd;
  int          errors;
  int          cycles;
  preg_t       last_old;          // Previous name from the latest rename
  areg_t       ra, rb;            // Registers shared by the CDB and rollback tests
  preg_t       pa, pb;

  rename_stage u_rename_stage (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic areg_t rand_areg();  // Never the zero register
    seed = xorshift32(seed);
    return areg_t'(seed % 31);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t: %s = %0d, expected %0d", $time, sig, got, exp);
    errors++;
  endtask

  task automatic reset_model();
    for (int i = 0; i < `MT_NUM; i++) begin
      m_map[i] = preg_t'(i);  // Identity map, all ready
      m_rdy[i] = 1'b1;
    end
    for (int i = 0; i < `FL_NUM; i++) begin
      fl_mem[i] = preg_t'(32 + i);
    end
    fl_head = 0;
    fl_tail = `FL_NUM;
    ck_cnt  = 0;
  endtask

  task automatic apply_cdb(input preg_t p);  // Live map and every stored copy
    for (int i = 0; i < `MT_NUM; i++) begin
      if (m_map[i] == p) m_rdy[i] = 1'b1;
      for (int s = 0; s < ck_cnt; s++) begin
        if (ck_map[s][i] == p) ck_rdy[s][i] = 1'b1;
      end
    end
  endtask

  task automatic save_checkpoint();
    for (int i = 0; i < `MT_NUM; i++) begin
      ck_map[ck_cnt][i] = m_map[i];
      ck_rdy[ck_cnt][i] = m_rdy[i];
    end
    ck_head[ck_cnt] = fl_head;
    ck_cnt++;
  endtask

  task automatic resolve_branch(input logic mispredict);
    if (mispredict) begin
      for (int i = 0; i < `MT_NUM; i++) begin
        m_map[i] = ck_map[0][i];
        m_rdy[i] = ck_rdy[0][i];
      end
      fl_head = ck_head[0];
      ck_cnt  = 0;  // Younger branches are gone too
    end else begin
      for (int s = 1; s < ck_cnt; s++) begin
        ck_head[s-1] = ck_head[s];
        for (int i = 0; i < `MT_NUM; i++) begin
          ck_map[s-1][i] = ck_map[s][i];
          ck_rdy[s-1][i] = ck_rdy[s][i];
        end
      end
      ck_cnt--;
    end
  endtask

  task automatic next_cycle();  // Drive point, inputs back to idle
    @(posedge clk);
    #1;
    dispatch_valid_i = 1'b0;
    is_branch_i      = 1'b0;
    dest_wr_i        = 1'b0;
    cdb_valid_i      = 1'b0;
    br_resolve_i     = 1'b0;
    br_mispredict_i  = 1'b0;
    retire_valid_i   = 1'b0;
  endtask

  task automatic check_reads(input areg_t a, input areg_t b);
    opa_areg_i = a;
    opb_areg_i = b;
    #1;  // Let the lookup settle
    if (opa_preg_o !== m_map[a]) report_mismatch("opa_preg_o", opa_preg_o, m_map[a]);
    if (opa_rdy_o !== m_rdy[a]) report_mismatch("opa_rdy_o", opa_rdy_o, m_rdy[a]);
    if (opb_preg_o !== m_map[b]) report_mismatch("opb_preg_o", opb_preg_o, m_map[b]);
    if (opb_rdy_o !== m_rdy[b]) report_mismatch("opb_rdy_o", opb_rdy_o, m_rdy[b]);
  endtask

  task automatic dispatch_write(input areg_t a);
    preg_t exp_new;
    next_cycle();
    dispatch_valid_i = 1'b1;
    dest_wr_i        = 1'b1;
    dest_areg_i      = a;
    exp_new          = fl_mem[fl_head % `FL_NUM];  // Head of the free list
    check_reads(a, areg_t'(`ZERO_REG));
    if (dispatch_ready_o !== 1'b1) report_mismatch("dispatch_ready_o", dispatch_ready_o, 1);
    if (dest_preg_o !== exp_new) report_mismatch("dest_preg_o", dest_preg_o, exp_new);
    if (dest_old_preg_o !== m_map[a]) begin
      report_mismatch("dest_old_preg_o", dest_old_preg_o, m_map[a]);
    end
    last_old = m_map[a];
    m_map[a] = exp_new;  // Visible after the coming edge, not ready
    m_rdy[a] = 1'b0;
    fl_head++;
  endtask

  task automatic dispatch_branch();
    next_cycle();
    dispatch_valid_i = 1'b1;
    is_branch_i      = 1'b1;
    dest_wr_i        = 1'b1;  // Must not rename
    dest_areg_i      = areg_t'(3);
    check_reads(areg_t'(3), areg_t'(4));
    if (dispatch_ready_o !== 1'b1) report_mismatch("dispatch_ready_o", dispatch_ready_o, 1);
    save_checkpoint();
  endtask

  task automatic check_reset_map();
    for (int i = 0; i < `MT_NUM; i++) begin
      next_cycle();
      check_reads(areg_t'(i), areg_t'(31 - i));
      if (dispatch_ready_o !== 1'b1) report_mismatch("dispatch_ready_o", dispatch_ready_o, 1);
    end
  endtask

  task automatic rename_random_writes();
    areg_t a;
    for (int n = 0; n < 8; n++) begin
      a = rand_areg();
      dispatch_write(a);
      next_cycle();
      check_reads(a, areg_t'(`ZERO_REG));  // New name, not ready
    end
    next_cycle();
    dispatch_valid_i = 1'b1;
    dest_wr_i        = 1'b1;
    dest_areg_i      = areg_t'(`ZERO_REG);
    check_reads(areg_t'(`ZERO_REG), areg_t'(`ZERO_REG));
    if (dispatch_ready_o !== 1'b1) report_mismatch("dispatch_ready_o", dispatch_ready_o, 1);
    if (dest_preg_o !== preg_t'(`ZERO_REG)) report_mismatch("dest_preg_o", dest_preg_o, 31);
    next_cycle();
    check_reads(areg_t'(`ZERO_REG), areg_t'(`ZERO_REG));
  endtask

  task automatic cdb_wakeup();
    ra = rand_areg();
    rb = areg_t'((int'(ra) + 1) % 31);
    dispatch_write(ra);  // Also proves the zero register write took no name
    dispatch_write(rb);
    pa = m_map[ra];
    next_cycle();
    cdb_valid_i = 1'b1;
    cdb_preg_i  = pa;
    check_reads(ra, rb);  // Stored bit only, no forwarding yet
    apply_cdb(pa);
    next_cycle();
    check_reads(ra, rb);
    if (opa_rdy_o !== 1'b1) report_mismatch("opa_rdy_o", opa_rdy_o, 1);
    if (opb_rdy_o !== 1'b0) report_mismatch("opb_rdy_o", opb_rdy_o, 0);
  endtask

  task automatic mispredict_rollback();
    preg_t first_new;
    pb = m_map[rb];
    dispatch_branch();
    first_new = fl_mem[fl_head % `FL_NUM];
    dispatch_write(ra);
    dispatch_write(rb);
    next_cycle();
    cdb_valid_i = 1'b1;
    cdb_preg_i  = pb;  // Old name of rb, now only in the checkpoint
    check_reads(ra, rb);
    apply_cdb(pb);
    next_cycle();
    br_resolve_i     = 1'b1;
    br_mispredict_i  = 1'b1;
    dispatch_valid_i = 1'b1;
    dest_wr_i        = 1'b1;
    dest_areg_i      = ra;
    check_reads(ra, rb);
    if (dispatch_ready_o !== 1'b0) report_mismatch("dispatch_ready_o", dispatch_ready_o, 0);
    resolve_branch(1'b1);
    next_cycle();
    dest_wr_i   = 1'b1;  // Valid low, only peeks at the next name
    dest_areg_i = ra;
    check_reads(ra, rb);
    if (opa_preg_o !== pa) report_mismatch("opa_preg_o", opa_preg_o, pa);
    if (opb_preg_o !== pb) report_mismatch("opb_preg_o", opb_preg_o, pb);
    if (opb_rdy_o !== 1'b1) report_mismatch("opb_rdy_o", opb_rdy_o, 1);
    if (dest_preg_o !== first_new) report_mismatch("dest_preg_o", dest_preg_o, first_new);
  endtask

  task automatic branch_queue_full();
    for (int k = 0; k < `CKPT_NUM; k++) begin
      dispatch_branch();
    end
    // Fifth branch held, resolve in the middle cycle, accepted in the last
    for (int k = 0; k < 3; k++) begin
      next_cycle();
      dispatch_valid_i = 1'b1;
      is_branch_i      = 1'b1;
      br_resolve_i     = (k == 1);
      check_reads(areg_t'(0), areg_t'(1));
      if (dispatch_ready_o !== (k == 2)) begin
        report_mismatch("dispatch_ready_o", dispatch_ready_o, (k == 2));
      end
      if (k == 1) resolve_branch(1'b0);
    end
    save_checkpoint();
    for (int k = 0; k < `CKPT_NUM; k++) begin
      next_cycle();
      br_resolve_i = 1'b1;  // Drain with correct predictions
      check_reads(areg_t'(0), areg_t'(1));
      resolve_branch(1'b0);
    end
  endtask

  task automatic free_list_exhaust();
    preg_t retired;
    while (fl_head != fl_tail) begin
      dispatch_write(rand_areg());
    end
    retired = last_old;
    next_cycle();
    dispatch_valid_i = 1'b1;
    dest_wr_i        = 1'b1;
    dest_areg_i      = areg_t'(0);
    check_reads(areg_t'(0), areg_t'(1));
    if (dispatch_ready_o !== 1'b0) report_mismatch("dispatch_ready_o", dispatch_ready_o, 0);
    next_cycle();
    dispatch_valid_i = 1'b1;
    dest_wr_i        = 1'b1;
    retire_valid_i   = 1'b1;
    retire_preg_i    = retired;
    check_reads(areg_t'(0), areg_t'(1));
    if (dispatch_ready_o !== 1'b0) report_mismatch("dispatch_ready_o", dispatch_ready_o, 0);
    fl_mem[fl_tail % `FL_NUM] = retired;
    fl_tail++;
    dispatch_write(areg_t'(0));
    if (dest_preg_o !== retired) report_mismatch("dest_preg_o", dest_preg_o, retired);
  endtask

  initial begin
    rst              = 1'b1;
    dispatch_valid_i = 1'b0;
    is_branch_i      = 1'b0;
    dest_wr_i        = 1'b0;
    opa_areg_i       = '0;
    opb_areg_i       = '0;
    dest_areg_i      = '0;
    cdb_valid_i      = 1'b0;
    cdb_preg_i       = '0;
    br_resolve_i     = 1'b0;
    br_mispredict_i  = 1'b0;
    retire_valid_i   = 1'b0;
    retire_preg_i    = '0;
    errors           = 0;
    cycles           = 0;
    reset_model();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_map();
    rename_random_writes();
    cdb_wakeup();
    mispredict_rollback();
    branch_queue_full();
    free_list_exhaust();
    $display("Tests run: 6, errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
rtl/rename_pkg.sv
rtl/ckpt_if.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/checkpoint_queue.sv
rtl/rename_stage.sv
tb/tb_rename_stage.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         := tb_rename_stage
RTL_TOP     := rename_stage
FILELIST    := all.f
OBJ_DIR     := obj_dir
PASS_MSG    := TESTBENCH PASSED
BUILD_FLAGS := --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
